// File: source/bca_ctrl_pkg.sv
package bca_ctrl_pkg;

  // step counter width, enough for the longest fill
  localparam int step_w = 4;

  // fill modes, encoding kept from the accelerator control FSM
  typedef enum logic [3:0] {
    idle      = 4'b0000,
    transpose = 4'b1001,
    inv       = 4'b1010,
    chi       = 4'b1011,
    nl_prd    = 4'b1100,
    nl_assoc  = 4'b1101,
    nl_new    = 4'b1110,
    nl_upd    = 4'b1111
  } fill_mode_e;

  // rows written per fill mode
  function automatic logic [step_w-1:0] mode_rows(input fill_mode_e mode);
    case (mode)
      nl_prd:    return step_w'(5);
      nl_new:    return step_w'(6);
      nl_upd:    return step_w'(7);
      nl_assoc:  return step_w'(7);
      transpose: return step_w'(4);
      inv:       return step_w'(10);
      chi:       return step_w'(11);
      default:   return '0;
    endcase
  endfunction

endpackage

// File: source/ekf_data_pkg.sv
package ekf_data_pkg;

  localparam int word_w = 32;

  // base address width carried in a fill request
  localparam int addr_w = 8;

  // measurement noise diagonal, fixed point
  localparam logic signed [word_w-1:0] q_11 = 32'h0008_0000;
  localparam logic signed [word_w-1:0] q_22 = 32'h0008_0000;

  // identity diagonal in the same format
  localparam logic signed [word_w-1:0] i_11 = 32'h0008_0000;
  localparam logic signed [word_w-1:0] i_22 = 32'h0008_0000;

  // jacobian terms from the EKF FSM
  typedef struct packed {
    logic signed [word_w-1:0] pad_1;
    logic signed [word_w-1:0] pad_0;
    logic signed [word_w-1:0] fxi_13;
    logic signed [word_w-1:0] fxi_23;
    logic signed [word_w-1:0] gxi_13;
    logic signed [word_w-1:0] gxi_23;
    logic signed [word_w-1:0] gz_11;
    logic signed [word_w-1:0] gz_12;
    logic signed [word_w-1:0] gz_21;
    logic signed [word_w-1:0] gz_22;
    logic signed [word_w-1:0] hz_11;
    logic signed [word_w-1:0] hz_12;
    logic signed [word_w-1:0] hz_21;
    logic signed [word_w-1:0] hz_22;
    logic signed [word_w-1:0] hxi_11;
    logic signed [word_w-1:0] hxi_12;
    logic signed [word_w-1:0] hxi_21;
    logic signed [word_w-1:0] hxi_22;
    logic signed [word_w-1:0] vt_1;
    logic signed [word_w-1:0] vt_2;
  } jacobian_t;

  // low four lanes of a cache row, lane_0 in the lsbs
  typedef struct packed {
    logic signed [word_w-1:0] lane_3;
    logic signed [word_w-1:0] lane_2;
    logic signed [word_w-1:0] lane_1;
    logic signed [word_w-1:0] lane_0;
  } base_row_t;

  typedef struct packed {
    bca_ctrl_pkg::fill_mode_e mode;
    logic [addr_w-1:0]        base;
  } fill_req_t;

endpackage

// File: source/bca_seq_ctrl.sv
`timescale 1ns/1ps

module bca_seq_ctrl #(
  parameter int depth = 32
) (
  input  logic                             clk,
  input  logic                             sys_rst,
  input  logic                             start,
  input  ekf_data_pkg::fill_req_t          req,
  output bca_ctrl_pkg::fill_mode_e         sel,
  output logic [bca_ctrl_pkg::step_w-1:0]  seq_cnt,
  output logic                             step_valid,
  output logic                             wr_en,
  output logic [$clog2(depth)-1:0]         wr_addr,
  output logic                             busy,
  output logic                             done
);

  localparam int aw = $clog2(depth);

  ekf_data_pkg::fill_req_t               req_q;
  logic [bca_ctrl_pkg::step_w-1:0]       rows;
  logic                                  last_step;
  logic [ekf_data_pkg::addr_w-1:0]       next_addr;

  assign rows      = bca_ctrl_pkg::mode_rows(req_q.mode);
  assign last_step = step_valid && (seq_cnt >= rows);
  assign sel       = req_q.mode;

  // row address for the current step, steps count from 1
  assign next_addr = req_q.base + ekf_data_pkg::addr_w'(seq_cnt) - 1'b1;

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      req_q      <= '{mode: bca_ctrl_pkg::idle, base: '0};
      seq_cnt    <= '0;
      step_valid <= 1'b0;
      busy       <= 1'b0;
    end else if (start && !busy) begin
      req_q      <= req;
      seq_cnt    <= bca_ctrl_pkg::step_w'(1);
      step_valid <= 1'b1;
      busy       <= 1'b1;
    end else if (last_step) begin
      seq_cnt    <= '0;
      step_valid <= 1'b0;
      busy       <= 1'b0;
    end else if (step_valid) begin
      seq_cnt <= seq_cnt + 1'b1;
    end
  end

  // write strobe and done line up with the mapper output register
  always_ff @(posedge clk) begin
    if (sys_rst) begin
      wr_en <= 1'b0;
      done  <= 1'b0;
    end else begin
      wr_en <= step_valid;
      done  <= last_step;
    end
  end

  always_ff @(posedge clk) begin
    if (step_valid) begin
      wr_addr <= next_addr[aw-1:0];
    end
  end

  // no back-pressure, so a second start during a fill is dropped
  a_no_start_busy: assert property (
    @(posedge clk) disable iff (sys_rst)
    start |-> !busy
  );

  // base plus mode length has to fit the cache
  a_addr_in_range: assert property (
    @(posedge clk) disable iff (sys_rst)
    step_valid |-> (next_addr < depth)
  );

endmodule

// File: source/b_cache_din_map.sv
`timescale 1ns/1ps

module b_cache_din_map #(
  parameter int lanes = 4
) (
  input  logic                                      clk,
  input  logic                                      sys_rst,
  input  bca_ctrl_pkg::fill_mode_e                  sel,
  input  logic [bca_ctrl_pkg::step_w-1:0]           seq_cnt,
  input  logic                                      step_valid,
  input  ekf_data_pkg::jacobian_t                   jac,
  input  logic [lanes-1:0][ekf_data_pkg::word_w-1:0] c_result,
  input  logic [lanes-1:0][ekf_data_pkg::word_w-1:0] tb_row,
  output logic [lanes-1:0][ekf_data_pkg::word_w-1:0] wr_row
);

  localparam int ww = ekf_data_pkg::word_w;

  logic signed [ww-1:0]              c0;
  logic signed [ww-1:0]              c1;
  logic signed [ww-1:0]              s_11;
  logic signed [ww-1:0]              s_12;
  logic signed [ww-1:0]              s_22;
  logic signed [ww-1:0]              p_11;
  logic signed [ww-1:0]              p_12;
  logic signed [ww-1:0]              det;
  ekf_data_pkg::base_row_t           base;
  logic [lanes-1:0][ww-1:0]          row_nxt;

  assign c0 = c_result[0];
  assign c1 = c_result[1];

  // 2x2 innovation covariance, det and adjugate only
  always_ff @(posedge clk) begin
    if (step_valid && sel == bca_ctrl_pkg::inv) begin
      case (seq_cnt)
        'd3: begin
          s_11 <= c0 + ekf_data_pkg::q_11;
        end
        'd4: begin
          s_12 <= c0;
          p_12 <= c0 * c1;
        end
        'd5: begin
          s_22 <= c1 + ekf_data_pkg::q_22;
          p_11 <= s_11 * c1;
        end
        'd6: begin
          det <= p_11 - p_12;
        end
        default: ;
      endcase
    end
  end

  // lanes 0..3 per mode and step
  always_comb begin
    base = '0;
    case (sel)
      bca_ctrl_pkg::nl_prd: begin
        case (seq_cnt)
          'd1: base.lane_0 = 1;
          'd3: begin
            base.lane_0 = jac.fxi_13;
            base.lane_1 = 1;
          end
          'd4: base.lane_1 = jac.fxi_23;
          'd5: base.lane_2 = 1;
          default: ;
        endcase
      end
      bca_ctrl_pkg::nl_new: begin
        case (seq_cnt)
          'd1: base.lane_0 = 1;
          'd3: begin
            base.lane_0 = jac.gxi_13;
            base.lane_1 = 1;
          end
          'd4: begin
            base.lane_0 = jac.gz_11;
            base.lane_1 = jac.gxi_23;
          end
          'd5: begin
            base.lane_0 = jac.gz_12;
            base.lane_1 = jac.gz_21;
          end
          'd6: base.lane_1 = jac.gz_22;
          default: ;
        endcase
      end
      // association shares the first five rows with update
      bca_ctrl_pkg::nl_upd, bca_ctrl_pkg::nl_assoc: begin
        case (seq_cnt)
          'd1: base.lane_0 = jac.hxi_11;
          'd2: begin
            base.lane_0 = jac.hxi_12;
            base.lane_1 = jac.hxi_21;
          end
          'd3: base.lane_1 = jac.hxi_22;
          'd4: begin
            base.lane_0 = jac.hz_11;
            base.lane_1 = -1;
          end
          'd5: begin
            base.lane_0 = jac.hz_12;
            base.lane_1 = jac.hz_21;
          end
          'd6: begin
            base.lane_0 = (sel == bca_ctrl_pkg::nl_upd) ? jac.vt_1 : ekf_data_pkg::i_11;
            base.lane_1 = jac.hz_22;
          end
          'd7: begin
            if (sel == bca_ctrl_pkg::nl_upd) begin
              base.lane_0 = jac.vt_2;
            end else begin
              base.lane_1 = ekf_data_pkg::i_22;
            end
          end
          default: ;
        endcase
      end
      bca_ctrl_pkg::inv: begin
        case (seq_cnt)
          'd7: base.lane_0 = s_22;
          'd8: begin
            base.lane_0 = -s_12;
            base.lane_1 = -s_12;
          end
          'd9: base.lane_1 = s_11;
          'd10: base.lane_0 = det;
          default: ;
        endcase
      end
      bca_ctrl_pkg::chi: begin
        if (seq_cnt == 'd10 || seq_cnt == 'd11) begin
          base.lane_0 = c0;
        end
      end
      default: ;
    endcase
  end

  // extra lanes stay zero except for transpose copies
  always_comb begin
    row_nxt      = '0;
    row_nxt[3:0] = base;
    if (sel == bca_ctrl_pkg::transpose) begin
      row_nxt = tb_row;
    end
  end

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      wr_row <= '0;
    end else if (step_valid) begin
      wr_row <= row_nxt;
    end
  end

  // sequencer only steps with a latched fill mode
  a_sel_not_idle: assert property (
    @(posedge clk) disable iff (sys_rst)
    step_valid |-> (sel != bca_ctrl_pkg::idle)
  );

endmodule

// File: source/b_cache.sv
`timescale 1ns/1ps

module b_cache #(
  parameter int lanes = 4,
  parameter int depth = 32
) (
  input  logic                                      clk,
  input  logic                                      wr_en,
  input  logic [$clog2(depth)-1:0]                  wr_addr,
  input  logic [lanes-1:0][ekf_data_pkg::word_w-1:0] wr_row,
  input  logic                                      rd_en,
  input  logic [$clog2(depth)-1:0]                  rd_addr,
  output logic [lanes-1:0][ekf_data_pkg::word_w-1:0] rd_data
);

  // one full row per entry
  logic [lanes-1:0][ekf_data_pkg::word_w-1:0] mem [depth];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_row;
    end
  end

  // registered read, old data on a same-address collision
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

// File: source/b_cache_subsys.sv
`timescale 1ns/1ps

module b_cache_subsys #(
  parameter int lanes = 4,
  parameter int depth = 32
) (
  input  logic                                      clk,
  input  logic                                      sys_rst,
  input  logic                                      start,
  input  ekf_data_pkg::fill_req_t                   req,
  input  ekf_data_pkg::jacobian_t                   jac,
  input  logic [lanes-1:0][ekf_data_pkg::word_w-1:0] c_result,
  input  logic [lanes-1:0][ekf_data_pkg::word_w-1:0] tb_row,
  input  logic                                      rd_en,
  input  logic [$clog2(depth)-1:0]                  rd_addr,
  output logic [lanes-1:0][ekf_data_pkg::word_w-1:0] rd_data,
  output logic                                      busy,
  output logic                                      done
);

  bca_ctrl_pkg::fill_mode_e                  sel;
  logic [bca_ctrl_pkg::step_w-1:0]           seq_cnt;
  logic                                      step_valid;
  logic                                      wr_en;
  logic [$clog2(depth)-1:0]                  wr_addr;
  logic [lanes-1:0][ekf_data_pkg::word_w-1:0] wr_row;

  bca_seq_ctrl #(
    .depth (depth)
  ) u_seq (
    .clk        (clk),
    .sys_rst    (sys_rst),
    .start      (start),
    .req        (req),
    .sel        (sel),
    .seq_cnt    (seq_cnt),
    .step_valid (step_valid),
    .wr_en      (wr_en),
    .wr_addr    (wr_addr),
    .busy       (busy),
    .done       (done)
  );

  b_cache_din_map #(
    .lanes (lanes)
  ) u_map (
    .clk        (clk),
    .sys_rst    (sys_rst),
    .sel        (sel),
    .seq_cnt    (seq_cnt),
    .step_valid (step_valid),
    .jac        (jac),
    .c_result   (c_result),
    .tb_row     (tb_row),
    .wr_row     (wr_row)
  );

  b_cache #(
    .lanes (lanes),
    .depth (depth)
  ) u_cache (
    .clk     (clk),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_row  (wr_row),
    .rd_en   (rd_en),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

endmodule

// File: test/tb_b_cache_subsys.sv
`timescale 1ns/1ps

module tb_b_cache_subsys;

  localparam int lanes     = 4;
  localparam int depth     = 32;
  localparam int ww        = ekf_data_pkg::word_w;
  localparam int aw        = $clog2(depth);
  localparam int num_tests = 10;

  typedef logic [lanes-1:0][ww-1:0] row_t;

  typedef struct packed {
    bca_ctrl_pkg::fill_mode_e        mode;
    logic [ekf_data_pkg::addr_w-1:0] base;
    logic                            readback;
  } test_t;

  logic                    clk;
  logic                    sys_rst;
  logic                    start;
  ekf_data_pkg::fill_req_t req;
  ekf_data_pkg::jacobian_t jac;
  row_t                    c_result;
  row_t                    tb_row;
  logic                    rd_en;
  logic [aw-1:0]           rd_addr;
  row_t                    rd_data;
  logic                    busy;
  logic                    done;

  row_t model_mem [depth];
  logic model_vld [depth];
  int   errors;

  // entries without readback run back to back with the next fill
  test_t tests [num_tests] = '{
    '{bca_ctrl_pkg::nl_prd,    8'd0,  1'b1},
    '{bca_ctrl_pkg::nl_new,    8'd5,  1'b1},
    '{bca_ctrl_pkg::nl_upd,    8'd11, 1'b1},
    '{bca_ctrl_pkg::nl_assoc,  8'd18, 1'b1},
    '{bca_ctrl_pkg::transpose, 8'd25, 1'b1},
    '{bca_ctrl_pkg::inv,       8'd20, 1'b1},
    '{bca_ctrl_pkg::chi,       8'd0,  1'b1},
    '{bca_ctrl_pkg::nl_prd,    8'd12, 1'b0},
    '{bca_ctrl_pkg::transpose, 8'd17, 1'b0},
    '{bca_ctrl_pkg::inv,       8'd21, 1'b1}
  };

  b_cache_subsys #(
    .lanes (lanes),
    .depth (depth)
  ) dut (
    .clk      (clk),
    .sys_rst  (sys_rst),
    .start    (start),
    .req      (req),
    .jac      (jac),
    .c_result (c_result),
    .tb_row   (tb_row),
    .rd_en    (rd_en),
    .rd_addr  (rd_addr),
    .rd_data  (rd_data),
    .busy     (busy),
    .done     (done)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  // rows written by one fill of each mode
  function automatic int fill_length(input bca_ctrl_pkg::fill_mode_e mode);
    case (mode)
      bca_ctrl_pkg::nl_prd:    return 5;
      bca_ctrl_pkg::nl_new:    return 6;
      bca_ctrl_pkg::nl_upd:    return 7;
      bca_ctrl_pkg::nl_assoc:  return 7;
      bca_ctrl_pkg::transpose: return 4;
      bca_ctrl_pkg::inv:       return 10;
      bca_ctrl_pkg::chi:       return 11;
      default:                 return 0;
    endcase
  endfunction

  // expected lanes for one step of a fill
  function automatic row_t expect_row(input bca_ctrl_pkg::fill_mode_e mode, input int step,
                                      input ekf_data_pkg::jacobian_t j, input row_t c,
                                      input row_t t);
    row_t            r;
    logic [ww-1:0]   s_11;
    logic [ww-1:0]   s_12;
    logic [ww-1:0]   s_22;
    logic [2*ww-1:0] prod_11;
    logic [2*ww-1:0] prod_12;
    logic [ww-1:0]   det;
    r       = '0;
    s_11    = c[0] + ekf_data_pkg::q_11;
    s_12    = c[0];
    s_22    = c[1] + ekf_data_pkg::q_22;
    prod_11 = s_11 * c[1];
    prod_12 = c[0] * c[1];
    det     = prod_11[ww-1:0] - prod_12[ww-1:0];
    case (mode)
      bca_ctrl_pkg::nl_prd: begin
        case (step)
          1: r[0] = 1;
          3: begin
            r[0] = j.fxi_13;
            r[1] = 1;
          end
          4: r[1] = j.fxi_23;
          5: r[2] = 1;
          default: ;
        endcase
      end
      bca_ctrl_pkg::nl_new: begin
        case (step)
          1: r[0] = 1;
          3: begin
            r[0] = j.gxi_13;
            r[1] = 1;
          end
          4: r = {64'd0, j.gxi_23, j.gz_11};
          5: r = {64'd0, j.gz_21, j.gz_12};
          6: r[1] = j.gz_22;
          default: ;
        endcase
      end
      bca_ctrl_pkg::nl_upd, bca_ctrl_pkg::nl_assoc: begin
        case (step)
          1: r[0] = j.hxi_11;
          2: r = {64'd0, j.hxi_21, j.hxi_12};
          3: r[1] = j.hxi_22;
          4: r = {64'd0, 32'hffff_ffff, j.hz_11};
          5: r = {64'd0, j.hz_21, j.hz_12};
          6: begin
            r[0] = (mode == bca_ctrl_pkg::nl_upd) ? j.vt_1 : ekf_data_pkg::i_11;
            r[1] = j.hz_22;
          end
          7: begin
            if (mode == bca_ctrl_pkg::nl_upd) r[0] = j.vt_2;
            else r[1] = ekf_data_pkg::i_22;
          end
          default: ;
        endcase
      end
      bca_ctrl_pkg::transpose: r = t;
      // adjugate rows then the determinant
      bca_ctrl_pkg::inv: begin
        case (step)
          7:  r[0] = s_22;
          8:  r = {64'd0, -s_12, -s_12};
          9:  r[1] = s_11;
          10: r[0] = det;
          default: ;
        endcase
      end
      bca_ctrl_pkg::chi: begin
        if (step >= 10) r[0] = c[0];
      end
      default: ;
    endcase
    return r;
  endfunction

  task automatic randomize_inputs();
    for (int i = 0; i < 20; i++) begin
      jac[i*ww +: ww] = $urandom;
    end
    for (int l = 0; l < lanes; l++) begin
      c_result[l] = $urandom;
      tb_row[l]   = $urandom;
    end
  endtask

  // starts a fill on the current falling edge and returns at the falling edge with done
  task automatic run_fill(input test_t t, output int latency, output bit busy_ok);
    randomize_inputs();
    req   = '{mode: t.mode, base: t.base};
    start = 1'b1;
    @(negedge clk);
    start   = 1'b0;
    latency = 1;
    busy_ok = 1'b1;
    while (!done) begin
      if (!busy) busy_ok = 1'b0;
      @(negedge clk);
      latency++;
    end
  endtask

  // one read per cycle, row returned on the next edge
  task automatic check_rows(input int lo, input int hi, output int bad);
    bad = 0;
    for (int a = lo; a <= hi; a++) begin
      rd_en   = 1'b1;
      rd_addr = aw'(a);
      @(negedge clk);
      if (model_vld[a]) begin
        for (int l = 0; l < lanes; l++) begin
          assert (rd_data[l] === model_mem[a][l]) else begin
            $display("mismatch rd_data addr %0d lane %0d: expected %h, got %h",
                     a, l, model_mem[a][l], rd_data[l]);
            bad++;
          end
        end
      end
    end
    rd_en = 1'b0;
  endtask

  initial begin
    int limit;
    limit = 100;
    for (int i = 0; i < num_tests; i++) begin
      limit += 4 * fill_length(tests[i].mode);
    end
    repeat (limit) @(posedge clk);
    $display("timeout after %0d cycles, a fill or readback never finished", limit);
    $display("Simulation failed");
    $finish;
  end

  initial begin
    test_t                    t;
    bca_ctrl_pkg::fill_mode_e mode;
    int                       rows;
    int                       base_i;
    int                       latency;
    int                       bad;
    int                       bad_rd;
    bit                       busy_ok;
    void'($urandom(4445));
    errors   = 0;
    start    = 1'b0;
    req      = '0;
    jac      = '0;
    c_result = '0;
    tb_row   = '0;
    rd_en    = 1'b0;
    rd_addr  = '0;
    for (int a = 0; a < depth; a++) begin
      model_mem[a] = '0;
      model_vld[a] = 1'b0;
    end
    sys_rst = 1'b1;
    repeat (16) @(negedge clk);
    sys_rst = 1'b0;
    @(negedge clk);
    assert (!busy && !done) else begin
      $display("mismatch busy/done after reset: expected 0/0, got %h/%h", busy, done);
      errors++;
    end

    for (int i = 0; i < num_tests; i++) begin
      t      = tests[i];
      mode   = t.mode;
      rows   = fill_length(mode);
      base_i = int'(t.base);
      bad    = 0;
      run_fill(t, latency, busy_ok);
      assert (latency == rows + 1) else begin
        $display("done came %0d cycles after start, expected %0d", latency, rows + 1);
        bad++;
      end
      assert (busy_ok && !busy) else begin
        $display("busy did not stay high during the fill or did not fall with done");
        bad++;
      end
      for (int s = 1; s <= rows; s++) begin
        model_mem[base_i + s - 1] = expect_row(mode, s, jac, c_result, tb_row);
        model_vld[base_i + s - 1] = 1'b1;
      end
      // neighbours of the written range too
      if (t.readback) begin
        check_rows((base_i > 0) ? base_i - 1 : 0,
                   (base_i + rows < depth) ? base_i + rows : depth - 1, bad_rd);
        bad += bad_rd;
      end
      errors += bad;
      $display("test %0d %s base %0d rows %0d: %0d errors", i, mode.name(), base_i, rows, bad);
    end

    check_rows(0, depth - 1, bad_rd);
    errors += bad_rd;
    $display("full readback sweep: %0d errors", bad_rd);
    $display("tests run: %0d, total errors: %0d", num_tests, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: compile.f
source/bca_ctrl_pkg.sv
source/ekf_data_pkg.sv
source/bca_seq_ctrl.sv
source/b_cache_din_map.sv
source/b_cache.sv
source/b_cache_subsys.sv
test/tb_b_cache_subsys.sv

// File: run_sim.sh
#!/bin/sh
# build with Verilator and run; pass only if the pass line shows up
verilator --binary --timing --assert -Wno-fatal \
  -f compile.f --top-module tb_b_cache_subsys -o sim_tb \
  && ./obj_dir/sim_tb | tee /dev/stderr \
  | grep "Simulation completed successfully" > /dev/null \
  && echo "run_sim: PASS" \
  || { echo "run_sim: FAIL"; exit 1; }
